// File: flist.f
+incdir+hw
hw/dcache_pkg.sv
hw/data_align.sv
hw/tag_data_array.sv
hw/mshr_file.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/mem_model.sv
verif/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS  ?= hw/dcache_pkg.sv hw/data_align.sv hw/tag_data_array.sv \
             hw/mshr_file.sv hw/dcache_ctrl.sv hw/dcache_top.sv
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+hw $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    typedef struct packed {
        logic [2:0] test;
        logic       store;
        mem_size_e  size;
        addr_t      addr;
        word_t      wdata;
        req_id_t    id;
    } op_t;

    localparam int NUM_OPS = 38;
    localparam int NUM_TESTS = 6;
    localparam int IDS = 1 << $bits(req_id_t);
    localparam int TIMEOUT = 60 * NUM_OPS + 200;

    // test, store, size, address, store data, id
    op_t ops [NUM_OPS] = '{
        '{3'd1, 1'b0, SIZE_WORD, 32'h0000_0100, 32'h0000_0000, 4'd0},
        '{3'd2, 1'b0, SIZE_WORD, 32'h0000_0100, 32'h0000_0000, 4'd1},
        '{3'd2, 1'b0, SIZE_BYTE, 32'h0000_0100, 32'h0000_0000, 4'd2},
        '{3'd2, 1'b0, SIZE_BYTE, 32'h0000_0101, 32'h0000_0000, 4'd3},
        '{3'd2, 1'b0, SIZE_BYTE, 32'h0000_0102, 32'h0000_0000, 4'd4},
        '{3'd2, 1'b0, SIZE_BYTE, 32'h0000_0103, 32'h0000_0000, 4'd5},
        '{3'd2, 1'b0, SIZE_HALF, 32'h0000_0100, 32'h0000_0000, 4'd6},
        '{3'd2, 1'b0, SIZE_HALF, 32'h0000_0102, 32'h0000_0000, 4'd7},
        '{3'd3, 1'b1, SIZE_BYTE, 32'h0000_0201, 32'h0000_00ab, 4'd8},
        '{3'd3, 1'b0, SIZE_WORD, 32'h0000_0200, 32'h0000_0000, 4'd9},
        '{3'd3, 1'b1, SIZE_HALF, 32'h0000_0202, 32'h0000_1234, 4'd10},
        '{3'd3, 1'b0, SIZE_WORD, 32'h0000_0200, 32'h0000_0000, 4'd11},
        '{3'd3, 1'b1, SIZE_WORD, 32'h0000_0204, 32'hdead_beef, 4'd12},
        '{3'd3, 1'b0, SIZE_BYTE, 32'h0000_0207, 32'h0000_0000, 4'd13},
        '{3'd3, 1'b0, SIZE_HALF, 32'h0000_0206, 32'h0000_0000, 4'd14},
        '{3'd3, 1'b0, SIZE_BYTE, 32'h0000_0202, 32'h0000_0000, 4'd15},
        '{3'd4, 1'b1, SIZE_WORD, 32'h0000_10c0, 32'hcafe_f00d, 4'd0},
        '{3'd4, 1'b0, SIZE_WORD, 32'h0000_20c0, 32'h0000_0000, 4'd1},   // Same index
        '{3'd4, 1'b0, SIZE_WORD, 32'h0000_10c0, 32'h0000_0000, 4'd2},
        '{3'd5, 1'b0, SIZE_WORD, 32'h0000_0508, 32'h0000_0000, 4'd3},
        '{3'd5, 1'b0, SIZE_WORD, 32'h0000_10c0, 32'h0000_0000, 4'd4},
        '{3'd5, 1'b0, SIZE_WORD, 32'h0000_050c, 32'h0000_0000, 4'd5},
        '{3'd5, 1'b0, SIZE_BYTE, 32'h0000_0200, 32'h0000_0000, 4'd6},
        '{3'd5, 1'b0, SIZE_WORD, 32'h0000_0510, 32'h0000_0000, 4'd7},
        '{3'd5, 1'b0, SIZE_HALF, 32'h0000_10c2, 32'h0000_0000, 4'd8},
        '{3'd5, 1'b0, SIZE_WORD, 32'h0000_0514, 32'h0000_0000, 4'd9},
        '{3'd5, 1'b1, SIZE_BYTE, 32'h0000_10c3, 32'h0000_0077, 4'd10},
        '{3'd5, 1'b0, SIZE_WORD, 32'h0000_10c0, 32'h0000_0000, 4'd11},
        '{3'd6, 1'b0, SIZE_WORD, 32'h0000_0620, 32'h0000_0000, 4'd12},
        '{3'd6, 1'b0, SIZE_WORD, 32'h0000_0624, 32'h0000_0000, 4'd13},
        '{3'd6, 1'b0, SIZE_WORD, 32'h0000_0628, 32'h0000_0000, 4'd14},
        '{3'd6, 1'b0, SIZE_WORD, 32'h0000_062c, 32'h0000_0000, 4'd15},
        '{3'd6, 1'b0, SIZE_WORD, 32'h0000_0630, 32'h0000_0000, 4'd0},
        '{3'd6, 1'b0, SIZE_WORD, 32'h0000_0618, 32'h0000_0000, 4'd1},
        '{3'd6, 1'b0, SIZE_WORD, 32'h0000_0718, 32'h0000_0000, 4'd2},
        '{3'd6, 1'b1, SIZE_BYTE, 32'h0000_0819, 32'h0000_005a, 4'd3},
        '{3'd6, 1'b0, SIZE_WORD, 32'h0000_0618, 32'h0000_0000, 4'd4},
        '{3'd6, 1'b0, SIZE_HALF, 32'h0000_081a, 32'h0000_0000, 4'd5}
    };

    string test_names [NUM_TESTS] = '{"reset and load miss", "repeated and sliced loads",
        "sized stores", "dirty writeback", "hits under misses", "conflict and full stalls"};

    logic      clk;
    logic      rst;
    logic      req_valid;
    logic      req_store;
    mem_size_e req_size;
    addr_t     req_addr;
    word_t     req_wdata;
    req_id_t   req_id;
    logic      req_ready;
    logic      resp_valid;
    req_id_t   resp_id;
    word_t     resp_rdata;
    logic      mem_req_valid;
    logic      mem_req_write;
    addr_t     mem_req_addr;
    word_t     mem_req_wdata;
    logic      mem_req_ready;
    logic      mem_resp_valid;
    word_t     mem_resp_data;

    word_t shadow [addr_t];    // By word address
    word_t expected [IDS];
    int    issued [IDS];
    int    answered [IDS];
    int    issued_total = 0;
    int    answered_total = 0;
    addr_t wb_addr [$];
    word_t wb_data [$];
    int    main_errors = 0;
    int    main_checks = 0;
    int    resp_errors = 0;
    int    resp_checks = 0;
    int    stalls = 0;
    int    cycle_count = 0;
    bit    id_ok;
    bit    data_ok;

    dcache_top uut (
        .clk, .rst,
        .req_valid, .req_store, .req_size, .req_addr, .req_wdata, .req_id, .req_ready,
        .resp_valid, .resp_id, .resp_rdata,
        .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata, .mem_req_ready,
        .mem_resp_valid, .mem_resp_data
    );

    mem_model u_mem (
        .clk, .rst,
        .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata, .mem_req_ready,
        .mem_resp_valid, .mem_resp_data
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic word_t shadow_word(input addr_t waddr);
        if (shadow.exists(waddr)) begin
            return shadow[waddr];
        end
        return waddr ^ 32'h5a5a_0000;
    endfunction

    function automatic int lane_shift(input mem_size_e size, input logic [1:0] offset);
        case (size)
            SIZE_BYTE: return 8 * int'(offset);
            SIZE_HALF: return 16 * int'(offset[1]);
            default: return 0;
        endcase
    endfunction

    function automatic word_t lane_mask(input mem_size_e size);
        case (size)
            SIZE_BYTE: return 32'h0000_00ff;
            SIZE_HALF: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp,
                              output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp,
                              output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input req_id_t id, output bit ok);
        ok = (issued[id] > answered[id]);
        if (!ok) begin
            $display("Error at %0t ns: a response came with id %0d, which has no request open",
                     $time, id);
        end
    endtask

    task automatic count_check(input bit ok);
        main_checks++;
        if (!ok) begin
            main_errors++;
        end
    endtask

    // Responses are matched by id, in any order
    always @(negedge clk) begin
        if (!rst && resp_valid) begin
            check_id(resp_id, id_ok);
            resp_checks++;
            if (!id_ok) begin
                resp_errors++;
            end else begin
                check_word("resp_rdata", resp_rdata, expected[resp_id], data_ok);
                resp_checks++;
                if (!data_ok) begin
                    resp_errors++;
                end
                answered[resp_id]++;
                answered_total++;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && mem_req_valid && mem_req_ready && mem_req_write) begin
            wb_addr.push_back(mem_req_addr);
            wb_data.push_back(mem_req_wdata);
        end
    end

    task automatic send_op(input op_t op);
        addr_t waddr;
        word_t old;
        word_t mask;
        int    shift;
        while (issued[op.id] != answered[op.id]) begin
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req_store = op.store;
        req_size = op.size;
        req_addr = op.addr;
        req_wdata = op.wdata;
        req_id = op.id;
        @(negedge clk);
        while (!req_ready) begin
            stalls++;
            @(negedge clk);
        end
        // Accepted at the next edge, so the shadow moves in acceptance order
        waddr = op.addr >> 2;
        old = shadow_word(waddr);
        shift = lane_shift(op.size, op.addr[1:0]);
        mask = lane_mask(op.size);
        if (op.store) begin
            shadow[waddr] = (old & ~(mask << shift)) | ((op.wdata & mask) << shift);
            expected[op.id] = '0;
        end else begin
            expected[op.id] = (old >> shift) & mask;
        end
        issued[op.id]++;
        issued_total++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain;
        while (issued_total != answered_total) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_reset;
        bit ok;
        @(negedge clk);
        check_flag("resp_valid", resp_valid, 1'b0, ok);
        count_check(ok);
        check_flag("mem_req_valid", mem_req_valid, 1'b0, ok);
        count_check(ok);
        check_flag("req_ready", req_ready, 1'b1, ok);
        count_check(ok);
        @(posedge clk);
        #1;
    endtask

    task automatic check_writeback(input addr_t addr);
        bit found;
        bit ok;
        found = 1'b0;
        foreach (wb_addr[i]) begin
            if (wb_addr[i] == addr) begin
                found = 1'b1;
                check_word("mem_req_wdata", wb_data[i], shadow_word(addr >> 2), ok);
                count_check(ok);
            end
        end
        if (!found) begin
            $display("Error at %0t ns: no memory write to 0x%08h was seen", $time, addr);
            count_check(1'b0);
        end
    endtask

    initial begin
        int errors_before;
        int passed_tests;
        int total_errors;
        passed_tests = 0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_size = SIZE_WORD;
        req_addr = '0;
        req_wdata = '0;
        req_id = '0;
        for (int i = 0; i < IDS; i++) begin
            issued[i] = 0;
            answered[i] = 0;
            expected[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            errors_before = main_errors + resp_errors;
            stalls = 0;
            if (t == 1) begin
                check_reset();
            end
            for (int i = 0; i < NUM_OPS; i++) begin
                if (int'(ops[i].test) == t) begin
                    send_op(ops[i]);
                end
            end
            drain();
            if (t == 4) begin
                check_writeback(32'h0000_10c0);     // Evicted by the same-index load
            end
            if (t == 6) begin
                count_check(stalls > 0);
                if (stalls == 0) begin
                    $display("Error at %0t ns: no request was held with req_ready low", $time);
                end
            end
            if (main_errors + resp_errors == errors_before) begin
                passed_tests++;
                $display("Test %0d (%s): ok", t, test_names[t-1]);
            end else begin
                $display("Test %0d (%s): FAIL", t, test_names[t-1]);
            end
        end
        total_errors = main_errors + resp_errors;
        $display("Summary: %0d of %0d tests ok, %0d checks, %0d errors",
                 passed_tests, NUM_TESTS, main_checks + resp_checks, total_errors);
        if (total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verif/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_req_valid,
    input  logic              mem_req_write,
    input  dcache_pkg::addr_t mem_req_addr,
    input  dcache_pkg::word_t mem_req_wdata,
    output logic              mem_req_ready,
    output logic              mem_resp_valid,
    output dcache_pkg::word_t mem_resp_data
);

    import dcache_pkg::*;

    word_t       contents [addr_t];     // Written words by word address
    word_t       read_data [$];
    int          read_due [$];
    logic [31:0] rng;
    int          cycle;
    logic        in_reset;
    logic        take;
    logic        take_write;
    addr_t       take_addr;
    word_t       take_wdata;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t read_word(input addr_t waddr);
        if (contents.exists(waddr)) begin
            return contents[waddr];
        end
        return waddr ^ 32'h5a5a_0000;
    endfunction

    initial begin
        rng = 32'hba74;
        cycle = 0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        forever begin
            @(negedge clk);
            in_reset = rst;
            take = mem_req_valid && mem_req_ready;  // Transfer at the coming edge
            take_write = mem_req_write;
            take_addr = mem_req_addr >> 2;
            take_wdata = mem_req_wdata;
            @(posedge clk);
            #1;
            cycle++;
            if (in_reset) begin
                mem_req_ready = 1'b0;
                mem_resp_valid = 1'b0;
            end else begin
                if (take && take_write) begin
                    contents[take_addr] = take_wdata;
                end else if (take) begin
                    rng = xorshift(rng);
                    read_data.push_back(read_word(take_addr));
                    read_due.push_back(cycle + int'(rng[2:0]));    // 1 to 8 cycles
                end
                // A slow head holds back the later reads
                mem_resp_valid = 1'b0;
                if (read_due.size() > 0 && read_due[0] <= cycle) begin
                    mem_resp_valid = 1'b1;
                    mem_resp_data = read_data.pop_front();
                    void'(read_due.pop_front());
                end
                rng = xorshift(rng);
                mem_req_ready = (rng[1:0] != 2'b00);
            end
        end
    end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic                  req_store,
    input  dcache_pkg::mem_size_e req_size,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::word_t     req_wdata,
    input  dcache_pkg::req_id_t   req_id,
    output logic                  req_ready,
    output logic                  resp_valid,
    output dcache_pkg::req_id_t   resp_id,
    output dcache_pkg::word_t     resp_rdata,
    output logic                  mem_req_valid,
    output logic                  mem_req_write,
    output dcache_pkg::addr_t     mem_req_addr,
    output dcache_pkg::word_t     mem_req_wdata,
    input  logic                  mem_req_ready,
    input  logic                  mem_resp_valid,
    input  dcache_pkg::word_t     mem_resp_data
);

    import dcache_pkg::*;

    index_t      req_index;
    index_t      rd_index;
    logic        rd_valid;
    logic        rd_dirty;
    tag_t        rd_tag;
    word_t       rd_data;
    logic        wr_en;
    index_t      wr_index;
    tag_t        wr_tag;
    word_t       wr_data;
    logic        wr_dirty;
    word_t       lookup_value;
    word_t       lookup_merged;
    word_t       fill_value;
    word_t       fill_merged;
    logic        full;
    logic        conflict;
    logic        empty;
    mshr_entry_t oldest;
    logic        fill_pending;
    logic        alloc;
    mshr_entry_t alloc_entry;
    logic        retire;
    logic        fill_issued;

    assign req_index = req_addr[2 +: $bits(index_t)];

    // Fill cycles look at the oldest miss' line
    assign rd_index = mem_resp_valid ? oldest.addr[2 +: $bits(index_t)] : req_index;

    dcache_ctrl u_ctrl (
        .clk, .rst,
        .req_valid, .req_store, .req_size, .req_addr, .req_wdata, .req_id, .req_ready,
        .resp_valid, .resp_id, .resp_rdata,
        .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata, .mem_req_ready,
        .mem_resp_valid, .mem_resp_data,
        .rd_valid, .rd_dirty, .rd_tag, .rd_data,
        .lookup_value, .lookup_merged, .fill_value, .fill_merged,
        .full, .conflict, .empty, .oldest, .fill_pending,
        .wr_en, .wr_index, .wr_tag, .wr_data, .wr_dirty,
        .alloc, .alloc_entry, .retire, .fill_issued
    );

    tag_data_array u_array (
        .clk, .rst,
        .rd_index, .rd_valid, .rd_dirty, .rd_tag, .rd_data,
        .wr_en, .wr_index, .wr_tag, .wr_data, .wr_dirty
    );

    mshr_file u_mshr (
        .clk, .rst,
        .alloc, .alloc_entry,
        .lookup_index (req_index),
        .retire, .full, .conflict, .empty, .oldest,
        .fill_pending, .fill_issued
    );

    data_align u_lookup_align (
        .size       (req_size),
        .offset     (req_addr[1:0]),
        .word       (rd_data),
        .store_data (req_wdata),
        .load_value (lookup_value),
        .merged     (lookup_merged)
    );

    // Store misses merge into the returned word
    data_align u_fill_align (
        .size       (oldest.size),
        .offset     (oldest.addr[1:0]),
        .word       (mem_resp_data),
        .store_data (oldest.wdata),
        .load_value (fill_value),
        .merged     (fill_merged)
    );

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic                    req_store,
    input  dcache_pkg::mem_size_e   req_size,
    input  dcache_pkg::addr_t       req_addr,
    input  dcache_pkg::word_t       req_wdata,
    input  dcache_pkg::req_id_t     req_id,
    output logic                    req_ready,
    output logic                    resp_valid,
    output dcache_pkg::req_id_t     resp_id,
    output dcache_pkg::word_t       resp_rdata,
    output logic                    mem_req_valid,
    output logic                    mem_req_write,
    output dcache_pkg::addr_t       mem_req_addr,
    output dcache_pkg::word_t       mem_req_wdata,
    input  logic                    mem_req_ready,
    input  logic                    mem_resp_valid,
    input  dcache_pkg::word_t       mem_resp_data,
    input  logic                    rd_valid,
    input  logic                    rd_dirty,
    input  dcache_pkg::tag_t        rd_tag,
    input  dcache_pkg::word_t       rd_data,
    input  dcache_pkg::word_t       lookup_value,
    input  dcache_pkg::word_t       lookup_merged,
    input  dcache_pkg::word_t       fill_value,
    input  dcache_pkg::word_t       fill_merged,
    input  logic                    full,
    input  logic                    conflict,
    input  logic                    empty,
    input  dcache_pkg::mshr_entry_t oldest,
    input  logic                    fill_pending,
    output logic                    wr_en,
    output dcache_pkg::index_t      wr_index,
    output dcache_pkg::tag_t        wr_tag,
    output dcache_pkg::word_t       wr_data,
    output logic                    wr_dirty,
    output logic                    alloc,
    output dcache_pkg::mshr_entry_t alloc_entry,
    output logic                    retire,
    output logic                    fill_issued
);

    import dcache_pkg::*;

    index_t req_index;
    tag_t   req_tag;
    logic   hit;
    logic   victim_dirty;
    addr_t  victim_addr;
    logic   accept;
    logic   new_wb;
    logic   out_free;
    logic   load_out;
    logic   next_write;
    addr_t  next_addr;
    word_t  next_wdata;
    logic   wb_pend_valid;
    addr_t  wb_pend_addr;
    word_t  wb_pend_data;

    assign req_index = req_addr[2 +: $bits(index_t)];
    assign req_tag = req_addr[$bits(addr_t)-1 -: $bits(tag_t)];

    assign hit = rd_valid && (rd_tag == req_tag);
    assign victim_dirty = rd_valid && rd_dirty && !hit;
    assign victim_addr = {rd_tag, req_index, 2'b00};

    // Stall on fills, conflicts, a full MSHR file or a taken writeback slot
    assign req_ready = !mem_resp_valid && !conflict && !full
                       && !(victim_dirty && wb_pend_valid);
    assign accept = req_valid && req_ready;
    assign alloc = accept && !hit;
    assign new_wb = alloc && victim_dirty;
    assign retire = mem_resp_valid && !empty;

    assign alloc_entry = '{
        valid:    1'b1,
        is_store: req_store,
        size:     req_size,
        addr:     req_addr,
        wdata:    req_wdata,
        id:       req_id
    };

    // Fills take the array write port over store hits
    always_comb begin
        wr_en = 1'b0;
        wr_index = req_index;
        wr_tag = req_tag;
        wr_data = lookup_merged;
        wr_dirty = 1'b1;
        if (retire) begin
            wr_en = 1'b1;
            wr_index = oldest.addr[2 +: $bits(index_t)];
            wr_tag = oldest.addr[$bits(addr_t)-1 -: $bits(tag_t)];
            wr_data = oldest.is_store ? fill_merged : mem_resp_data;
            wr_dirty = oldest.is_store;
        end else if (accept && hit && req_store) begin
            wr_en = 1'b1;
        end
    end

    assign out_free = !mem_req_valid || mem_req_ready;

    // Writebacks always go ahead of the next fill read
    always_comb begin
        load_out = 1'b1;
        fill_issued = 1'b0;
        next_write = 1'b1;
        next_addr = wb_pend_addr;
        next_wdata = wb_pend_data;
        if (!wb_pend_valid) begin
            if (new_wb) begin
                next_addr = victim_addr;
                next_wdata = rd_data;
            end else if (fill_pending) begin
                next_write = 1'b0;
                next_addr = {oldest.addr[$bits(addr_t)-1:2], 2'b00};
                next_wdata = '0;
                fill_issued = out_free;
            end else begin
                load_out = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
            mem_req_valid <= 1'b0;
            wb_pend_valid <= 1'b0;
        end else begin
            resp_valid <= retire || (accept && hit);
            if (out_free) begin
                mem_req_valid <= load_out;
            end
            if (out_free && wb_pend_valid) begin
                wb_pend_valid <= 1'b0;
            end else if (!out_free && new_wb) begin
                wb_pend_valid <= 1'b1;  // Park the victim while the channel is busy
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            resp_id <= oldest.id;
            resp_rdata <= oldest.is_store ? '0 : fill_value;
        end else if (accept) begin
            resp_id <= req_id;
            resp_rdata <= req_store ? '0 : lookup_value;
        end
        if (out_free && load_out) begin
            mem_req_write <= next_write;
            mem_req_addr <= next_addr;
            mem_req_wdata <= next_wdata;
        end
        if (!out_free && new_wb) begin
            wb_pend_addr <= victim_addr;
            wb_pend_data <= rd_data;
        end
    end

endmodule

// File: hw/mshr_file.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module mshr_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc,
    input  dcache_pkg::mshr_entry_t alloc_entry,
    input  dcache_pkg::index_t      lookup_index,
    input  logic                    retire,
    output logic                    full,
    output logic                    conflict,
    output logic                    empty,
    output dcache_pkg::mshr_entry_t oldest,
    output logic                    fill_pending,
    input  logic                    fill_issued
);

    import dcache_pkg::*;

    localparam int DEPTH = `DCACHE_MSHRS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

    mshr_entry_t      entries [DEPTH];
    logic [PTR_W-1:0] head;     // Oldest entry, next to retire
    logic [PTR_W-1:0] tail;     // Next free slot
    logic [PTR_W-1:0] fill_ptr; // Next entry whose read is unsent
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
            head <= '0;
            tail <= '0;
            fill_ptr <= '0;
            count <= '0;
        end else begin
            // Memory answers in order, so the head is always the one filled
            if (retire) begin
                entries[head].valid <= 1'b0;
                head <= next_ptr(head);
            end
            if (alloc) begin
                entries[tail] <= alloc_entry;
                tail <= next_ptr(tail);
            end
            if (fill_issued) begin
                fill_ptr <= next_ptr(fill_ptr);
            end
            case ({alloc, retire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_comb begin
        conflict = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (entries[i].valid && entries[i].addr[2 +: $bits(index_t)] == lookup_index) begin
                conflict = 1'b1;
            end
        end
    end

    assign full = (count == FULL_COUNT);
    assign empty = (count == '0);
    assign oldest = entries[head];

    // Reads go out one at a time, for the oldest entry only
    assign fill_pending = !empty && (fill_ptr == head);

endmodule

// File: hw/tag_data_array.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tag_data_array (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t rd_index,
    output logic               rd_valid,
    output logic               rd_dirty,
    output dcache_pkg::tag_t   rd_tag,
    output dcache_pkg::word_t  rd_data,
    input  logic               wr_en,
    input  dcache_pkg::index_t wr_index,
    input  dcache_pkg::tag_t   wr_tag,
    input  dcache_pkg::word_t  wr_data,
    input  logic               wr_dirty
);

    import dcache_pkg::*;

    localparam int LINES = `DCACHE_LINES;

    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;
    tag_t             tag_mem  [LINES];
    word_t            data_mem [LINES];

    // State bits cleared on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= 1'b1;
            dirty_q[wr_index] <= wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
            data_mem[wr_index] <= wr_data;
        end
    end

    // Combinational lookup
    assign rd_valid = valid_q[rd_index];
    assign rd_dirty = dirty_q[rd_index];
    assign rd_tag = tag_mem[rd_index];
    assign rd_data = data_mem[rd_index];

endmodule

// File: hw/data_align.sv
`timescale 1ns/1ps

module data_align (
    input  dcache_pkg::mem_size_e size,
    input  logic [1:0]            offset,
    input  dcache_pkg::word_t     word,
    input  dcache_pkg::word_t     store_data,
    output dcache_pkg::word_t     load_value,
    output dcache_pkg::word_t     merged
);

    import dcache_pkg::*;

    logic [4:0] byte_lsb;
    logic [4:0] half_lsb;

    assign byte_lsb = {offset, 3'b000};
    assign half_lsb = {offset[1], 4'b0000};

    always_comb begin
        load_value = '0;    // Zero extension
        merged = word;
        case (size)
            SIZE_BYTE: begin
                load_value[7:0] = word[byte_lsb +: 8];
                merged[byte_lsb +: 8] = store_data[7:0];
            end
            SIZE_HALF: begin
                load_value[15:0] = word[half_lsb +: 16];
                merged[half_lsb +: 16] = store_data[15:0];
            end
            default: begin
                load_value = word;
                merged = store_data;
            end
        endcase
    end

endmodule

// File: hw/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DCACHE_XLEN-1:0] word_t;
    typedef logic [`DCACHE_XLEN-1:0] addr_t;

    // Index sits just above the byte offset
    typedef logic [$clog2(`DCACHE_LINES)-1:0] index_t;
    typedef logic [`DCACHE_XLEN-$clog2(`DCACHE_LINES)-3:0] tag_t;

    typedef logic [`DCACHE_ID_W-1:0] req_id_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // One outstanding miss, oldest first in the MSHR file
    typedef struct packed {
        logic      valid;
        logic      is_store;
        mem_size_e size;
        addr_t     addr;
        word_t     wdata;   // Store data merged at fill time
        req_id_t   id;
    } mshr_entry_t;

endpackage

// File: hw/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Data and address width
`define DCACHE_XLEN 32

// One word per line, direct mapped
`define DCACHE_LINES 64

// Outstanding misses
`define DCACHE_MSHRS 4

`define DCACHE_ID_W 4

`endif
